//--- build.f
+incdir+source
source/alloc_pkg.sv
source/rr_arbiter.sv
source/switch_allocator.sv
source/alloc_top.sv
tests/alloc_asserts.sv
tests/alloc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the allocator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 -f build.f --top-module alloc_tb -o alloc_sim \
  > sim.log 2>&1 \
  && ./obj_dir/alloc_sim >> sim.log 2>&1 \
  || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
exit 0

//--- tests/alloc_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "alloc_consts.svh"

module alloc_tb
  import alloc_pkg::*;
();

  // Clock and run lengths
  localparam int          CLK_HALF      = 5;
  localparam int          RESET_CYCLES  = 10;
  localparam int          RANDOM_CYCLES = 2000;
  localparam int          MAX_CYCLES    = 3000;
  // Cycles allowed for the last checks to drain
  localparam int          CHECK_LIMIT   = 10;
  localparam logic [31:0] SEED          = 32'he9a9_e0bd;

  // Model pointer state, one entry per arbiter
  typedef int in_ptrs_t [`ALLOC_NUM_IN];
  typedef int out_ptrs_t [`ALLOC_NUM_OUT];

  logic        clk;
  logic        arst_n;
  req_matrix_t request;
  req_matrix_t grant;

  in_ptrs_t    model_in_ptr;
  out_ptrs_t   model_out_ptr;
  req_matrix_t model_grant;
  string       test_name;
  string       check_name;
  int          checks_done = 0;
  int          error_count = 0;

  alloc_top UUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .request (request),
    .grant   (grant)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------

  // Input-first separable matching with iSLIP pointer moves
  function automatic req_matrix_t ref_allocate(
    input req_matrix_t req,
    inout in_ptrs_t    in_ptr,
    inout out_ptrs_t   out_ptr
  );
    req_matrix_t pick;
    req_matrix_t result;
    int          idx;
    int          win;
    pick   = '0;
    result = '0;
    // Each requester takes its first request at or after its pointer
    for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
      win = -1;
      for (int k = 0; k < `ALLOC_NUM_OUT; k++) begin
        idx = (in_ptr[i] + k) % `ALLOC_NUM_OUT;
        if (win < 0 && req[i][idx]) begin
          win = idx;
        end
      end
      if (win >= 0) begin
        pick[i][win] = 1'b1;
      end
    end
    // Each resource takes the first picking requester from its pointer
    for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
      win = -1;
      for (int k = 0; k < `ALLOC_NUM_IN; k++) begin
        idx = (out_ptr[j] + k) % `ALLOC_NUM_IN;
        if (win < 0 && pick[idx][j]) begin
          win = idx;
        end
      end
      if (win >= 0) begin
        result[win][j] = 1'b1;
        out_ptr[j]     = (win + 1) % `ALLOC_NUM_IN;
      end
    end
    // Input pointer moves only past an accepted pick
    for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
      for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
        if (result[i][j]) begin
          in_ptr[i] = (j + 1) % `ALLOC_NUM_OUT;
        end
      end
    end
    return result;
  endfunction

  task automatic fail_mismatch(input string name, input req_matrix_t exp_val,
                               input req_matrix_t act_val);
    error_count++;
    $display("Mismatch in %s: expected %h, actual %h", name, exp_val, act_val);
    $display("TEST FAIL");
    $fatal(1, "Grant differs from the expected value");
  endtask

  task automatic fail_with(input string msg);
    error_count++;
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Testbench stopped on an error");
  endtask

  // ----------------------------------------
  // Comparison process
  // ----------------------------------------

  // Model steps on the rising edge
  // Grant compared at the falling edge
  always begin
    @(posedge clk);
    if (arst_n) begin
      model_grant = ref_allocate(request, model_in_ptr, model_out_ptr);
    end else begin
      model_grant = '0;
      for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
        model_in_ptr[i] = 0;
      end
      for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
        model_out_ptr[j] = 0;
      end
    end
    check_name = test_name;
    @(negedge clk);
    assert (grant === model_grant) else fail_mismatch(check_name, model_grant, grant);
    checks_done++;
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------

  // New request matrix just after the rising edge
  task automatic drive_request(input req_matrix_t r);
    @(posedge clk);
    #1;
    request = r;
  endtask

  task automatic wait_checks(input int target);
    int waited;
    waited = 0;
    while (checks_done < target && waited < CHECK_LIMIT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (checks_done < target) begin
      fail_with("Timeout waiting for the grant checker to finish");
    end
  endtask

  // Whole-run watchdog
  initial begin
    for (int c = 0; c < MAX_CYCLES; c++) begin
      #(2 * CLK_HALF);
    end
    fail_with("Timeout: simulation exceeded its cycle limit");
  end

  initial begin
    req_matrix_t single;
    req_matrix_t all_req;
    in_vec_t     served;
    logic [31:0] rnd;
    rnd       = $urandom(SEED);
    all_req   = '1;
    arst_n    = 1'b0;
    // Requests held high so only the reset keeps grant at zero
    request   = all_req;
    test_name = "reset";

    // Release after the reset cycles
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // First cycle after release still shows the reset value
    assert (grant === '0) else fail_mismatch(test_name, '0, grant);
    drive_request('0);

    // One lone request bit at a time
    test_name = "single requester";
    for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
      for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
        single       = '0;
        single[i][j] = 1'b1;
        drive_request(single);
        drive_request('0);
        assert (grant === single) else fail_mismatch(test_name, single, grant);
      end
    end

    // Full load over four windows
    // Grant of cycle c-1 is read in iteration c
    test_name = "full load";
    served    = '0;
    for (int c = 0; c <= 4 * `ALLOC_NUM_IN; c++) begin
      if (c < 4 * `ALLOC_NUM_IN) begin
        drive_request(all_req);
      end else begin
        drive_request('0);
      end
      if (c > 0) begin
        for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
          if (|grant[i]) begin
            served[i] = 1'b1;
          end
        end
        // Pointers desynchronized by now
        if (c - 1 >= `ALLOC_NUM_IN) begin
          assert ($countones(grant) == `ALLOC_NUM_IN)
            else fail_with("Full load grant is not a full permutation");
        end
        if (c % `ALLOC_NUM_IN == 0) begin
          assert (served == '1)
            else fail_with("A requester got no grant within a full load window");
          served = '0;
        end
      end
    end

    // Idle cycles leave every pointer in place
    test_name = "empty requests";
    repeat (5) begin
      drive_request('0);
      assert (grant === '0) else fail_mismatch(test_name, '0, grant);
    end

    // Random request matrices against the model
    test_name = "random traffic";
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      rnd = $urandom();
      drive_request(rnd[`ALLOC_NUM_IN*`ALLOC_NUM_OUT-1:0]);
    end
    drive_request('0);
    wait_checks(checks_done + 2);

    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/alloc_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "alloc_consts.svh"

// Grant register must always form a legal matching
module alloc_asserts
  import alloc_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input req_matrix_t request,
  input req_matrix_t grant
);

  // At most one resource per requester
  function automatic logic rows_legal(input req_matrix_t m);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
      if (!$onehot0(m[i])) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // At most one requester per resource
  function automatic logic cols_legal(input req_matrix_t m);
    logic    ok;
    in_vec_t col;
    ok = 1'b1;
    for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
      for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
        col[i] = m[i][j];
      end
      if (!$onehot0(col)) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // ----------------------------------------
  // Matching properties
  // ----------------------------------------

  a_rows_onehot0: assert property (@(posedge clk) disable iff (!arst_n) rows_legal(grant))
    else $error("Grant row holds more than one bit");

  a_cols_onehot0: assert property (@(posedge clk) disable iff (!arst_n) cols_legal(grant))
    else $error("Grant column holds more than one bit");

  // Grant only where the previous edge saw a request
  a_subset: assert property (@(posedge clk) disable iff (!arst_n)
    (grant & ~$past(request)) == '0)
    else $error("Grant bit set without a matching request");

  // Checked mid-cycle, after the async reset has settled
  a_reset_zero: assert property (@(negedge clk) !arst_n |-> grant == '0)
    else $error("Grant not zero during reset");

endmodule

bind switch_allocator alloc_asserts u_asserts (
  .clk     (clk),
  .arst_n  (arst_n),
  .request (request),
  .grant   (grant)
);

`default_nettype wire

//--- source/alloc_top.sv
`timescale 1ns/1ns
`default_nettype none

// Allocator subsystem boundary
// Counts come from the consts header through the package types
// Request bit [i][j] means requester i wants resource j
// Grant follows request by one clock
// No back-pressure, a losing requester just holds its request
module alloc_top
  import alloc_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  req_matrix_t request,
  output req_matrix_t grant
);

  // ----------------------------------------
  // Allocator core
  // ----------------------------------------

  // Input-first separable matching
  // Grant rows and columns are at most one-hot
  switch_allocator u_alloc (
    .clk     (clk),
    .arst_n  (arst_n),
    .request (request),
    .grant   (grant)
  );

endmodule

`default_nettype wire

//--- source/switch_allocator.sv
`timescale 1ns/1ns
`default_nettype none

`include "alloc_consts.svh"

// Separable allocator, input first
// Stage one picks one resource per requester
// Stage two picks one requester per resource
// Matching is registered, one cycle from request to grant
module switch_allocator
  import alloc_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  req_matrix_t request,
  output req_matrix_t grant
);

  // Input stage winners, one-hot per requester row
  req_matrix_t in_win;

  // Same winners seen per resource
  col_matrix_t in_win_col;

  // Output stage winners, one-hot per resource column
  col_matrix_t out_win_col;

  // Final matching before the register
  req_matrix_t match;

  // Pointer strobes for the input arbiters
  in_vec_t in_upd;

  // Pointer strobes for the output arbiters
  out_vec_t out_upd;

  // ----------------------------------------
  // Input stage
  // ----------------------------------------

  // One arbiter per requester over its request row
  // Pointer moves only if the pick also won the output stage
  for (genvar i = 0; i < `ALLOC_NUM_IN; i++) begin : g_in_arb
    rr_arbiter #(
      .WIDTH (`ALLOC_NUM_OUT)
    ) u_in_arb (
      .clk       (clk),
      .arst_n    (arst_n),
      .request   (request[i]),
      .update_en (in_upd[i]),
      .grant     (in_win[i])
    );
  end

  // Rows to columns
  // Column j lists every requester whose pick was resource j
  always_comb begin
    for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
      for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
        in_win_col[j][i] = in_win[i][j];
      end
    end
  end

  // ----------------------------------------
  // Output stage
  // ----------------------------------------

  // One arbiter per resource over its column
  for (genvar j = 0; j < `ALLOC_NUM_OUT; j++) begin : g_out_arb
    rr_arbiter #(
      .WIDTH (`ALLOC_NUM_IN)
    ) u_out_arb (
      .clk       (clk),
      .arst_n    (arst_n),
      .request   (in_win_col[j]),
      .update_en (out_upd[j]),
      .grant     (out_win_col[j])
    );
  end

  // Any granted requester moves the output pointer
  always_comb begin
    for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
      out_upd[j] = |out_win_col[j];
    end
  end

  // Columns back to rows
  // At most one bit per row, since each row entered one-hot
  always_comb begin
    for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
      for (int j = 0; j < `ALLOC_NUM_OUT; j++) begin
        match[i][j] = out_win_col[j][i];
      end
    end
  end

  // ----------------------------------------
  // iSLIP pointer rule, input side
  // ----------------------------------------

  // Input pick survived the output stage
  // A losing pick keeps its priority for the next cycle
  always_comb begin
    for (int i = 0; i < `ALLOC_NUM_IN; i++) begin
      in_upd[i] = |(in_win[i] & match[i]);
    end
  end

  // ----------------------------------------
  // Grant register
  // ----------------------------------------

  // Same edge as the pointer updates
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      grant <= '0;
    end else begin
      grant <= match;
    end
  end

endmodule

`default_nettype wire

//--- source/rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

// Round-robin arbiter built on a programmable priority encoder
// Grant is combinational from request and the stored pointer
// Pointer moves only when update_en is high at the clock edge
module rr_arbiter #(
  parameter int WIDTH = 4
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [WIDTH-1:0] request,
  input  logic             update_en,
  output logic [WIDTH-1:0] grant
);

  // Pointer width, at least one bit for the single input case
  localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

  // Index into the request vector
  typedef logic [PTR_W-1:0] ptr_t;

  // Highest valid index, used for the wrap
  localparam ptr_t LAST_IDX = ptr_t'(WIDTH - 1);

  // Current highest priority position
  ptr_t ptr_q;

  // Pointer value after a granted cycle
  ptr_t ptr_next;

  // Index of the winning request
  ptr_t win_idx;

  // Some request bit is set
  logic found;

  // Request vector laid twice side by side
  logic [2*WIDTH-1:0] req_dbl;

  // Doubled vector shifted so that bit 0 sits at the pointer
  logic [2*WIDTH-1:0] req_rot;

  // ----------------------------------------
  // Priority search
  // ----------------------------------------

  // Doubling removes the wrap from the search
  assign req_dbl = {request, request};

  // Rotate by the pointer
  assign req_rot = req_dbl >> ptr_q;

  // First set bit at or above the pointer, cyclically
  always_comb begin
    found   = 1'b0;
    win_idx = '0;
    for (int k = 0; k < WIDTH; k++) begin
      if (!found && req_rot[k]) begin
        found = 1'b1;
        // Map back from rotated to absolute position
        win_idx = ptr_t'((int'(ptr_q) + k) % WIDTH);
      end
    end
  end

  // One-hot grant, all zero with no request
  always_comb begin
    grant = '0;
    if (found) begin
      grant[win_idx] = 1'b1;
    end
  end

  // ----------------------------------------
  // Pointer update
  // ----------------------------------------

  // One past the winner, modulo WIDTH
  always_comb begin
    if (win_idx == LAST_IDX) begin
      ptr_next = '0;
    end else begin
      ptr_next = win_idx + ptr_t'(1);
    end
  end

  // Holds unless the caller confirms the grant
  // An idle cycle never moves the pointer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q <= '0;
    end else if (update_en && found) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

`default_nettype wire

//--- source/alloc_pkg.sv
`default_nettype none

`include "alloc_consts.svh"

package alloc_pkg;

  // ----------------------------------------
  // Row and column vectors
  // ----------------------------------------

  // One bit per resource
  // A single requester's request row or grant row
  typedef logic [`ALLOC_NUM_OUT-1:0] out_vec_t;

  // One bit per requester
  // A single resource's column after the transpose
  typedef logic [`ALLOC_NUM_IN-1:0] in_vec_t;

  // ----------------------------------------
  // Matrices
  // ----------------------------------------

  // Indexed by requester, then resource
  // Bit [i][j] set means requester i and resource j
  // Carries both the request and the grant matrix
  typedef out_vec_t [`ALLOC_NUM_IN-1:0] req_matrix_t;

  // Indexed by resource, then requester
  // Transposed view seen by the output stage
  typedef in_vec_t [`ALLOC_NUM_OUT-1:0] col_matrix_t;

endpackage

`default_nettype wire

//--- source/alloc_consts.svh
`ifndef ALLOC_CONSTS_SVH
`define ALLOC_CONSTS_SVH

// ----------------------------------------
// Allocator dimensions
// ----------------------------------------

// Requesters on the input side
// One request row per requester
`define ALLOC_NUM_IN  4

// Resources on the output side
// One column per resource after the transpose
`define ALLOC_NUM_OUT 4

`endif
